// File: hw/conv_cfg.svh
`ifndef CONV_CFG_SVH
`define CONV_CFG_SVH

// data word and finalsum width
`define BIT_LENGTH 16

// fifo entries, power of two for the gray pointers
`define FIFO_DEPTH 32
`define FIFO_AW 5

// products per 3x3 window
`define WINDOW_TAPS 9

// wide enough for nine full products
`define ACC_LENGTH 36

`endif

// File: hw/convPkg.sv
`include "conv_cfg.svh"

package convPkg;

    // one word from the host stream
    typedef logic signed [`BIT_LENGTH-1:0] sample_t;

    // running sum of products
    typedef logic signed [`ACC_LENGTH-1:0] acc_t;

    // operand fetch sequence
    typedef enum logic [1:0] {
        IDLE,
        PIXEL,
        WEIGHT,
        ISSUE
    } fetchState_t;

endpackage

// File: hw/sampleFifo.sv
`include "conv_cfg.svh"
`timescale 1ns/100ps

module sampleFifo (
    input  logic             Clk,
    input  logic             reset,
    input  logic             wrClk,
    input  logic             wr,
    input  convPkg::sample_t dataInput,
    input  logic             rdEn,
    output convPkg::sample_t rdData,
    output logic             FULL,
    output logic             EMPTY
);
    import convPkg::*;

    localparam int AW = `FIFO_AW;

    sample_t mem [0:`FIFO_DEPTH-1];

    // write side, pointers carry one extra wrap bit
    logic [AW:0] wrBin;
    logic [AW:0] wrGray;
    logic [AW:0] wrBinNext;
    logic [AW:0] wrGrayNext;
    logic [AW:0] rdGraySync1;
    logic [AW:0] rdGraySync2;
    logic        wrAccept;
    logic        fullNext;

    // read side
    logic [AW:0] rdBin;
    logic [AW:0] rdGray;
    logic [AW:0] rdBinNext;
    logic [AW:0] rdGrayNext;
    logic [AW:0] wrGraySync1;
    logic [AW:0] wrGraySync2;
    logic        rdAccept;
    logic        emptyNext;

    assign wrAccept   = wr && !FULL;
    assign wrBinNext  = wrBin + {{AW{1'b0}}, wrAccept};
    assign wrGrayNext = (wrBinNext >> 1) ^ wrBinNext;

    // full when the write pointer laps the read pointer
    assign fullNext = (wrGrayNext == {~rdGraySync2[AW:AW-1], rdGraySync2[AW-2:0]});

    always_ff @(posedge wrClk) begin
        if (wrAccept) begin
            mem[wrBin[AW-1:0]] <= dataInput;
        end
    end

    always_ff @(posedge wrClk) begin
        if (reset) begin
            wrBin       <= '0;
            wrGray      <= '0;
            rdGraySync1 <= '0;
            rdGraySync2 <= '0;
            FULL        <= 1'b0;
        end else begin
            wrBin       <= wrBinNext;
            wrGray      <= wrGrayNext;
            rdGraySync1 <= rdGray;
            rdGraySync2 <= rdGraySync1;
            FULL        <= fullNext;
        end
    end

    assign rdAccept   = rdEn && !EMPTY;
    assign rdBinNext  = rdBin + {{AW{1'b0}}, rdAccept};
    assign rdGrayNext = (rdBinNext >> 1) ^ rdBinNext;
    assign emptyNext  = (rdGrayNext == wrGraySync2);

    // word appears one Clk after the pop
    always_ff @(posedge Clk) begin
        if (rdAccept) begin
            rdData <= mem[rdBin[AW-1:0]];
        end
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            rdBin       <= '0;
            rdGray      <= '0;
            wrGraySync1 <= '0;
            wrGraySync2 <= '0;
            EMPTY       <= 1'b1;
        end else begin
            rdBin       <= rdBinNext;
            rdGray      <= rdGrayNext;
            wrGraySync1 <= wrGray;
            wrGraySync2 <= wrGraySync1;
            EMPTY       <= emptyNext;
        end
    end

    // fetch must never pop an empty buffer
    noPopWhenEmpty: assert property (
        @(posedge Clk) disable iff (reset) rdEn |-> !EMPTY
    );

endmodule

// File: hw/operandFetch.sv
`timescale 1ns/100ps

module operandFetch (
    input  logic             Clk,
    input  logic             reset,
    input  logic             cStart,
    input  logic             EMPTY,
    input  convPkg::sample_t rdData,
    output logic             rdEn,
    output convPkg::sample_t pixel,
    output convPkg::sample_t weight,
    output logic             tapValid
);
    import convPkg::*;

    fetchState_t state;
    fetchState_t nextState;

    always_comb begin
        nextState = state;
        rdEn      = 1'b0;
        case (state)
            IDLE: begin
                // new pair only while started
                if (cStart && !EMPTY) begin
                    rdEn      = 1'b1;
                    nextState = PIXEL;
                end
            end
            PIXEL: begin
                // pixel is on rdData now, wait for its weight
                if (!EMPTY) begin
                    rdEn      = 1'b1;
                    nextState = WEIGHT;
                end
            end
            WEIGHT: begin
                nextState = ISSUE;
            end
            ISSUE: begin
                nextState = IDLE;
            end
            default: begin
                nextState = IDLE;
            end
        endcase
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    // rdData holds until the next pop, so latch on the weight pop
    always_ff @(posedge Clk) begin
        if (state == PIXEL && rdEn) begin
            pixel <= rdData;
        end
        if (state == WEIGHT) begin
            weight <= rdData;
        end
    end

    assign tapValid = (state == ISSUE);

    tapValidPulse: assert property (
        @(posedge Clk) disable iff (reset) tapValid |=> !tapValid
    );

endmodule

// File: hw/macAccumulator.sv
`include "conv_cfg.svh"
`timescale 1ns/100ps

module macAccumulator (
    input  logic             Clk,
    input  logic             reset,
    input  convPkg::sample_t pixel,
    input  convPkg::sample_t weight,
    input  logic             tapValid,
    output convPkg::sample_t finalsum,
    output logic             cReady
);
    import convPkg::*;

    localparam int TapBits = $clog2(`WINDOW_TAPS);
    localparam logic [TapBits-1:0] LastTap = TapBits'(`WINDOW_TAPS - 1);

    acc_t               product;
    logic               prodValid;
    acc_t               sum;
    acc_t               sumNext;
    logic [TapBits-1:0] tapCount;

    // product stage
    always_ff @(posedge Clk) begin
        if (tapValid) begin
            product <= acc_t'(pixel) * acc_t'(weight);
        end
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            prodValid <= 1'b0;
        end else begin
            prodValid <= tapValid;
        end
    end

    assign sumNext = sum + product;

    // accumulate stage, ninth tap closes the window
    always_ff @(posedge Clk) begin
        if (reset) begin
            sum      <= '0;
            tapCount <= '0;
            finalsum <= '0;
            cReady   <= 1'b0;
        end else begin
            cReady <= 1'b0;
            if (prodValid) begin
                if (tapCount == LastTap) begin
                    // wraps modulo 2^16
                    finalsum <= sumNext[`BIT_LENGTH-1:0];
                    cReady   <= 1'b1;
                    sum      <= '0;
                    tapCount <= '0;
                end else begin
                    sum      <= sumNext;
                    tapCount <= tapCount + 1'b1;
                end
            end
        end
    end

    cReadyPulse: assert property (
        @(posedge Clk) disable iff (reset) cReady |=> !cReady
    );

endmodule

// File: hw/ConvolutionAccelerator.sv
`timescale 1ns/100ps

module ConvolutionAccelerator (
    input  logic             Clk,
    input  logic             reset,
    input  convPkg::sample_t dataInput,
    input  logic             cStart,
    input  logic             wr,
    input  logic             wrClk,
    output convPkg::sample_t finalsum,
    output logic             cReady,
    output logic             FULL,
    output logic             EMPTY
);
    import convPkg::*;

    logic    rdEn;
    sample_t rdData;
    sample_t pixel;
    sample_t weight;
    logic    tapValid;

    // host stream buffer
    sampleFifo fifo0 (
        .Clk       (Clk),
        .reset     (reset),
        .wrClk     (wrClk),
        .wr        (wr),
        .dataInput (dataInput),
        .rdEn      (rdEn),
        .rdData    (rdData),
        .FULL      (FULL),
        .EMPTY     (EMPTY)
    );

    operandFetch fetch0 (
        .Clk      (Clk),
        .reset    (reset),
        .cStart   (cStart),
        .EMPTY    (EMPTY),
        .rdData   (rdData),
        .rdEn     (rdEn),
        .pixel    (pixel),
        .weight   (weight),
        .tapValid (tapValid)
    );

    macAccumulator mac0 (
        .Clk      (Clk),
        .reset    (reset),
        .pixel    (pixel),
        .weight   (weight),
        .tapValid (tapValid),
        .finalsum (finalsum),
        .cReady   (cReady)
    );

endmodule

// File: testbench/convolveTb.sv
`include "conv_cfg.svh"
`timescale 1ns/100ps

module convolveTb;
    import convPkg::*;

    localparam int ClkPeriod   = 40;
    localparam int WrClkPeriod = 60;
    localparam int NumWindows  = 8;
    localparam int WindowWords = 2 * `WINDOW_TAPS;

    logic    Clk;
    logic    reset;
    logic    wrClk;
    logic    wr;
    logic    cStart;
    sample_t dataInput;
    sample_t finalsum;
    logic    cReady;
    logic    FULL;
    logic    EMPTY;

    // pixel, weight, pixel, weight ... per window
    sample_t stimTable [0:NumWindows-1][0:WindowWords-1];
    sample_t expectTable [0:NumWindows-1];
    sample_t expectQ [$];
    sample_t expectedSum;
    integer  seed = 32'hdc6d_a5c2;

    ConvolutionAccelerator dut0 (
        .Clk       (Clk),
        .reset     (reset),
        .dataInput (dataInput),
        .cStart    (cStart),
        .wr        (wr),
        .wrClk     (wrClk),
        .finalsum  (finalsum),
        .cReady    (cReady),
        .FULL      (FULL),
        .EMPTY     (EMPTY)
    );

    initial begin
        Clk = 1'b0;
        forever #(ClkPeriod / 2) Clk = ~Clk;
    end

    initial begin
        wrClk = 1'b0;
        forever #(WrClkPeriod / 2) wrClk = ~wrClk;
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("STATUS: FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic checkSample(input string name, input sample_t actual, input sample_t expected);
        if (actual !== expected) begin
            abortRun($sformatf("mismatch at %0t: %s got %0d (0x%h) expected %0d (0x%h)",
                $time, name, actual, actual, expected, expected));
        end
    endtask

    task automatic checkFlag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            abortRun($sformatf("mismatch at %0t: %s got %b expected %b",
                $time, name, actual, expected));
        end
    endtask

    // reference sum, wide accumulate then wrap to the word width
    function automatic sample_t windowSum(input int w);
        acc_t acc;
        int   k;
        acc = '0;
        for (k = 0; k < `WINDOW_TAPS; k++) begin
            acc += acc_t'(stimTable[w][2*k]) * acc_t'(stimTable[w][2*k+1]);
        end
        return sample_t'(acc[`BIT_LENGTH-1:0]);
    endfunction

    task automatic buildTable();
        int w;
        int k;
        for (w = 0; w < NumWindows; w++) begin
            for (k = 0; k < WindowWords; k++) begin
                stimTable[w][k] = sample_t'($random(seed));
            end
        end
        // small ramp with mixed sign weights
        for (k = 0; k < `WINDOW_TAPS; k++) begin
            stimTable[0][2*k]   = sample_t'(k + 1);
            stimTable[0][2*k+1] = sample_t'(k - 4);
        end
        // extreme values, every product overflows the word
        for (k = 0; k < `WINDOW_TAPS; k++) begin
            stimTable[4][2*k]   = (k % 2 == 0) ? 16'sh7fff : 16'sh8000;
            stimTable[4][2*k+1] = (k % 3 == 0) ? 16'sh8000 : 16'sh7ffe;
        end
        for (w = 0; w < NumWindows; w++) begin
            expectTable[w] = windowSum(w);
        end
    endtask

    // word is taken on the edge after the negedge that sees FULL low
    task automatic pushWord(input sample_t word);
        @(posedge wrClk);
        wr        <= 1'b1;
        dataInput <= word;
        @(negedge wrClk);
        while (FULL) begin
            @(negedge wrClk);
        end
    endtask

    task automatic endWrite();
        @(posedge wrClk);
        wr <= 1'b0;
    endtask

    task automatic sendWords(input int w, input int first, input int last);
        int i;
        for (i = first; i < last; i++) begin
            pushWord(stimTable[w][i]);
        end
    endtask

    task automatic setStart(input logic value);
        @(posedge Clk);
        cStart <= value;
    endtask

    task automatic waitDrain();
        while (expectQ.size() != 0) begin
            @(negedge Clk);
        end
        // quiet time to catch a stray result
        repeat (20) @(negedge Clk);
    endtask

    always @(negedge Clk) begin
        if (!reset && cReady) begin
            if (expectQ.size() == 0) begin
                abortRun("cReady pulsed while no window was outstanding");
            end else begin
                expectedSum = expectQ.pop_front();
                checkSample("finalsum", finalsum, expectedSum);
            end
        end
    end

    initial begin
        #(NumWindows * 200 * ClkPeriod + 100 * ClkPeriod);
        abortRun("timeout: the run did not finish within the watchdog limit");
    end

    initial begin
        int w;
        reset     = 1'b1;
        wr        = 1'b0;
        cStart    = 1'b0;
        dataInput = '0;
        buildTable();
        repeat (3) @(posedge Clk);
        reset <= 1'b0;

        // idle write clock, nothing stored
        repeat (10) @(posedge wrClk);
        @(negedge Clk);
        checkFlag("EMPTY", EMPTY, 1'b1);
        checkFlag("FULL", FULL, 1'b0);

        setStart(1'b1);
        expectQ.push_back(expectTable[0]);
        sendWords(0, 0, WindowWords);
        endWrite();
        waitDrain();

        // back to back, last one overflows
        for (w = 1; w <= 4; w++) begin
            expectQ.push_back(expectTable[w]);
            sendWords(w, 0, WindowWords);
        end
        endWrite();
        waitDrain();

        // fill the buffer while stopped, 33rd word is dropped
        setStart(1'b0);
        sendWords(5, 0, WindowWords);
        sendWords(6, 0, 14);
        @(posedge wrClk);
        wr        <= 1'b1;
        dataInput <= 16'sh5a5a;
        @(negedge wrClk);
        checkFlag("FULL", FULL, 1'b1);
        @(posedge wrClk);
        wr <= 1'b0;
        expectQ.push_back(expectTable[5]);
        expectQ.push_back(expectTable[6]);
        setStart(1'b1);
        sendWords(6, 14, WindowWords);
        endWrite();
        waitDrain();

        // pause mid window
        setStart(1'b0);
        sendWords(7, 0, WindowWords);
        endWrite();
        repeat (8) @(negedge Clk);
        checkFlag("EMPTY", EMPTY, 1'b0);
        setStart(1'b1);
        repeat (20) @(posedge Clk);
        setStart(1'b0);
        repeat (60) @(negedge Clk);
        checkFlag("EMPTY", EMPTY, 1'b0);
        expectQ.push_back(expectTable[7]);
        setStart(1'b1);
        waitDrain();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+hw
hw/convPkg.sv
hw/sampleFifo.sv
hw/operandFetch.sv
hw/macAccumulator.sv
hw/ConvolutionAccelerator.sv
testbench/convolveTb.sv

// File: run.sh
#!/bin/sh
# build and run the convolution testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module convolveTb -o convolveSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/convolveSim 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "STATUS: PASS"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1
